// ==== rtl/mem_sched_params.svh ====
`ifndef MEM_SCHED_PARAMS_SVH
`define MEM_SCHED_PARAMS_SVH

// Address and byte offset width
`define MS_ADDR_W 32

// Loop counter width
`define MS_ITER_W 16

// Array width, also the default number of X reads per tile
`define MS_ARRAY_W 4

// Group index width in the gidx word
`define MS_GIDX_W 8

// Bytes per memory word and data-to-memory width ratio
`define MS_NUM_BYTE 4
`define MS_DATA_RATIO 4

// Byte jump between two column tiles of X
`define MS_JMP (`MS_NUM_BYTE * (`MS_DATA_RATIO - 1))

`endif

// ==== rtl/mem_sched_pkg.sv ====
`include "mem_sched_params.svh"

package mem_sched_pkg;

  // Byte address or byte offset
  typedef logic [`MS_ADDR_W-1:0] addr_t;

  // Loop iteration count
  typedef logic [`MS_ITER_W-1:0] iter_t;

  // Quantisation mode of the weights
  typedef enum logic [1:0] {
    QINT_2 = 2'd0,
    QINT_4 = 2'd1,
    QINT_8 = 2'd2
  } qmode_e;

  // Word carried on the group-index stream
  // Skip flag sits right above the index
  typedef struct packed {
    logic                  skip;
    logic [`MS_GIDX_W-1:0] idx;
  } gidx_word_t;

endpackage

// ==== rtl/loop_cfg_if.sv ====
`include "mem_sched_params.svh"

interface loop_cfg_if;

  mem_sched_pkg::iter_t cols_iters;
  mem_sched_pkg::iter_t rows_iters;
  mem_sched_pkg::iter_t w_iters;
  mem_sched_pkg::addr_t rows_offs;
  mem_sched_pkg::iter_t tot_x_read;

  // Reads on the last row, zero means a full tile
  logic [$clog2(`MS_ARRAY_W):0] leftover_rows;

  modport cfg (
    output cols_iters,
    output rows_iters,
    output w_iters,
    output rows_offs,
    output tot_x_read,
    output leftover_rows
  );

  modport walker (
    input cols_iters,
    input rows_iters,
    input w_iters,
    input rows_offs,
    input tot_x_read,
    input leftover_rows
  );

endinterface

// ==== rtl/x_tile_walker.sv ====
`include "mem_sched_params.svh"

module x_tile_walker #(
  parameter int unsigned ArrayW = `MS_ARRAY_W,
  localparam int unsigned LenW  = $clog2(ArrayW) + 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 x_done_i,
  loop_cfg_if.walker           cfg,
  output mem_sched_pkg::addr_t x_offs_o,
  output logic [LenW-1:0]      x_len_o,
  output logic                 x_reload_o
);

  mem_sched_pkg::iter_t cols_q;
  mem_sched_pkg::iter_t w_q;
  mem_sched_pkg::iter_t rows_q;
  mem_sched_pkg::iter_t tot_read_q;
  mem_sched_pkg::addr_t cols_offs_q;
  mem_sched_pkg::addr_t rows_offs_q;

  mem_sched_pkg::iter_t cols_max;
  mem_sched_pkg::iter_t w_max;
  mem_sched_pkg::iter_t rows_max;

  logic cols_last;
  logic w_last;
  logic rows_last;

  assign cols_max = cfg.cols_iters - 1'b1;
  assign w_max    = cfg.w_iters - 1'b1;
  assign rows_max = cfg.rows_iters - 1'b1;

  assign cols_last = (cols_q == cols_max);
  assign w_last    = (w_q == w_max);
  assign rows_last = (rows_q == rows_max);

  // Columns innermost, then W passes, then rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q      <= '0;
      w_q         <= '0;
      rows_q      <= '0;
      tot_read_q  <= '0;
      cols_offs_q <= '0;
      rows_offs_q <= '0;
    end else if (clear_i) begin
      cols_q      <= '0;
      w_q         <= '0;
      rows_q      <= '0;
      tot_read_q  <= '0;
      cols_offs_q <= '0;
      rows_offs_q <= '0;
    end else if (x_done_i) begin
      tot_read_q <= tot_read_q + 1'b1;
      if (cols_last) begin
        cols_q      <= '0;
        cols_offs_q <= '0;
        w_q         <= w_last ? '0 : w_q + 1'b1;
        if (w_last) begin
          rows_q      <= rows_last ? '0 : rows_q + 1'b1;
          rows_offs_q <= rows_last ? '0 : rows_offs_q + cfg.rows_offs;
        end
      end else begin
        cols_q      <= cols_q + 1'b1;
        cols_offs_q <= cols_offs_q + mem_sched_pkg::addr_t'(`MS_JMP);
      end
    end
  end

  assign x_offs_o = rows_offs_q + cols_offs_q;

  // Short tile on the last row when leftovers are programmed
  assign x_len_o = (rows_last && (cfg.leftover_rows != '0)) ? cfg.leftover_rows
                                                            : LenW'(ArrayW);

  // Re-issue between the first and the last read
  assign x_reload_o = (tot_read_q != '0) && (tot_read_q != cfg.tot_x_read);

  a_cols_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cfg.cols_iters != '0) |-> (cols_q <= cols_max)
  ) else $error("x_tile_walker: column counter past cols_iters-1");

endmodule

// ==== rtl/dequant_offset_gen.sv ====
module dequant_offset_gen (
  input  mem_sched_pkg::qmode_e     qmode_i,
  input  mem_sched_pkg::addr_t      w_d0_stride_i,
  input  logic                      gidx_valid_i,
  input  mem_sched_pkg::gidx_word_t gidx_i,
  output logic                      gidx_ready_o,
  output logic                      offs_valid_o,
  input  logic                      offs_ready_i,
  output mem_sched_pkg::addr_t      scales_offs_o,
  output mem_sched_pkg::addr_t      zeros_offs_o,
  output logic                      group_skip_o,
  input  logic                      row_valid_i,
  input  mem_sched_pkg::iter_t      row_idx_i,
  output logic                      row_ready_o,
  output logic                      wq_valid_o,
  input  logic                      wq_ready_i,
  output mem_sched_pkg::addr_t      wq_offs_o,
  output logic [1:0]                q_shift_o
);

  logic [15:0] stride_lo;
  logic [15:0] stride_packed;

  // Fewer bits per weight means more weights per byte
  always_comb begin
    case (qmode_i)
      mem_sched_pkg::QINT_2: q_shift_o = 2'd3;
      mem_sched_pkg::QINT_4: q_shift_o = 2'd2;
      default:               q_shift_o = 2'd1;
    endcase
  end

  assign stride_lo     = w_d0_stride_i[15:0];
  assign stride_packed = stride_lo >> q_shift_o;

  // Group index path, scales and zeros share one handshake
  assign gidx_ready_o  = offs_ready_i;
  assign offs_valid_o  = gidx_valid_i && offs_ready_i;
  assign scales_offs_o = mem_sched_pkg::addr_t'(gidx_i.idx) *
                         mem_sched_pkg::addr_t'(stride_lo);
  assign zeros_offs_o  = mem_sched_pkg::addr_t'(gidx_i.idx) *
                         mem_sched_pkg::addr_t'(stride_packed);
  assign group_skip_o  = gidx_i.skip;

  // Row index path into the quantised weights
  assign row_ready_o = wq_ready_i;
  assign wq_valid_o  = row_valid_i && wq_ready_i;
  assign wq_offs_o   = mem_sched_pkg::addr_t'(row_idx_i) *
                       mem_sched_pkg::addr_t'(stride_packed);

endmodule

// ==== rtl/stream_ctrl_builder.sv ====
`include "mem_sched_params.svh"

module stream_ctrl_builder #(
  localparam int unsigned LenW = $clog2(`MS_ARRAY_W) + 1
) (
  input  mem_sched_pkg::addr_t x_addr_i,
  input  mem_sched_pkg::addr_t w_addr_i,
  input  mem_sched_pkg::addr_t scales_addr_i,
  input  mem_sched_pkg::addr_t w_d0_stride_i,
  input  logic                 dequant_en_i,
  input  logic                 first_load_i,
  input  logic                 x_ready_start_i,
  input  logic                 w_ready_start_i,
  input  logic                 wq_ready_start_i,
  input  mem_sched_pkg::addr_t x_offs_i,
  input  logic [LenW-1:0]      x_len_i,
  input  logic                 x_reload_i,
  input  logic [1:0]           q_shift_i,
  output mem_sched_pkg::addr_t x_base_addr_o,
  output mem_sched_pkg::addr_t w_base_addr_o,
  output mem_sched_pkg::addr_t w_stride_o,
  output mem_sched_pkg::addr_t wq_d2_stride_o,
  output logic [LenW-1:0]      x_tot_len_o,
  output logic                 x_req_start_o,
  output logic                 w_req_start_o,
  output logic                 wq_req_start_o,
  output logic                 ignore_bias_o
);

  // X descriptor
  assign x_base_addr_o = x_addr_i + x_offs_i;
  assign x_tot_len_o   = x_len_i;

  // W port loads the scales when dequantising
  always_comb begin
    if (dequant_en_i) begin
      w_base_addr_o = scales_addr_i;
      w_stride_o    = '0;
      ignore_bias_o = 1'b0;
    end else begin
      w_base_addr_o = w_addr_i;
      w_stride_o    = w_d0_stride_i;
      ignore_bias_o = 1'b1;
    end
  end

  // Packed weights advance by a fraction of the X jump
  assign wq_d2_stride_o = mem_sched_pkg::addr_t'(`MS_JMP) >> q_shift_i;

  // Start requests
  assign x_req_start_o  = (first_load_i || x_reload_i) && x_ready_start_i;
  assign w_req_start_o  = first_load_i && w_ready_start_i;
  assign wq_req_start_o = dequant_en_i && first_load_i && wq_ready_start_i;

endmodule

// ==== rtl/mem_scheduler_top.sv ====
`include "mem_sched_params.svh"

module mem_scheduler_top #(
  localparam int unsigned LenW = $clog2(`MS_ARRAY_W) + 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      x_done_i,
  input  mem_sched_pkg::iter_t      cols_iters_i,
  input  mem_sched_pkg::iter_t      rows_iters_i,
  input  mem_sched_pkg::iter_t      w_iters_i,
  input  mem_sched_pkg::addr_t      rows_offs_i,
  input  mem_sched_pkg::iter_t      tot_x_read_i,
  input  logic [LenW-1:0]           leftover_rows_i,
  input  mem_sched_pkg::addr_t      x_addr_i,
  input  mem_sched_pkg::addr_t      w_addr_i,
  input  mem_sched_pkg::addr_t      scales_addr_i,
  input  mem_sched_pkg::addr_t      w_d0_stride_i,
  input  logic                      dequant_en_i,
  input  logic                      first_load_i,
  input  logic                      x_ready_start_i,
  input  logic                      w_ready_start_i,
  input  logic                      wq_ready_start_i,
  input  mem_sched_pkg::qmode_e     qmode_i,
  input  logic                      gidx_valid_i,
  input  mem_sched_pkg::gidx_word_t gidx_i,
  output logic                      gidx_ready_o,
  output logic                      offs_valid_o,
  input  logic                      offs_ready_i,
  output mem_sched_pkg::addr_t      scales_offs_o,
  output mem_sched_pkg::addr_t      zeros_offs_o,
  output logic                      group_skip_o,
  input  logic                      row_valid_i,
  input  mem_sched_pkg::iter_t      row_idx_i,
  output logic                      row_ready_o,
  output logic                      wq_valid_o,
  input  logic                      wq_ready_i,
  output mem_sched_pkg::addr_t      wq_offs_o,
  output mem_sched_pkg::addr_t      x_base_addr_o,
  output mem_sched_pkg::addr_t      w_base_addr_o,
  output mem_sched_pkg::addr_t      w_stride_o,
  output mem_sched_pkg::addr_t      wq_d2_stride_o,
  output logic [LenW-1:0]           x_tot_len_o,
  output logic                      x_req_start_o,
  output logic                      w_req_start_o,
  output logic                      wq_req_start_o,
  output logic                      ignore_bias_o
);

  mem_sched_pkg::addr_t x_offs;
  logic [LenW-1:0]      x_len;
  logic                 x_reload;
  logic [1:0]           q_shift;

  loop_cfg_if loop_cfg ();

  assign loop_cfg.cols_iters    = cols_iters_i;
  assign loop_cfg.rows_iters    = rows_iters_i;
  assign loop_cfg.w_iters       = w_iters_i;
  assign loop_cfg.rows_offs     = rows_offs_i;
  assign loop_cfg.tot_x_read    = tot_x_read_i;
  assign loop_cfg.leftover_rows = leftover_rows_i;

  x_tile_walker #(
    .ArrayW (`MS_ARRAY_W)
  ) i_x_tile_walker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .x_done_i   (x_done_i),
    .cfg        (loop_cfg),
    .x_offs_o   (x_offs),
    .x_len_o    (x_len),
    .x_reload_o (x_reload)
  );

  dequant_offset_gen i_dequant_offset_gen (
    .qmode_i       (qmode_i),
    .w_d0_stride_i (w_d0_stride_i),
    .gidx_valid_i  (gidx_valid_i),
    .gidx_i        (gidx_i),
    .gidx_ready_o  (gidx_ready_o),
    .offs_valid_o  (offs_valid_o),
    .offs_ready_i  (offs_ready_i),
    .scales_offs_o (scales_offs_o),
    .zeros_offs_o  (zeros_offs_o),
    .group_skip_o  (group_skip_o),
    .row_valid_i   (row_valid_i),
    .row_idx_i     (row_idx_i),
    .row_ready_o   (row_ready_o),
    .wq_valid_o    (wq_valid_o),
    .wq_ready_i    (wq_ready_i),
    .wq_offs_o     (wq_offs_o),
    .q_shift_o     (q_shift)
  );

  stream_ctrl_builder i_stream_ctrl_builder (
    .x_addr_i         (x_addr_i),
    .w_addr_i         (w_addr_i),
    .scales_addr_i    (scales_addr_i),
    .w_d0_stride_i    (w_d0_stride_i),
    .dequant_en_i     (dequant_en_i),
    .first_load_i     (first_load_i),
    .x_ready_start_i  (x_ready_start_i),
    .w_ready_start_i  (w_ready_start_i),
    .wq_ready_start_i (wq_ready_start_i),
    .x_offs_i         (x_offs),
    .x_len_i          (x_len),
    .x_reload_i       (x_reload),
    .q_shift_i        (q_shift),
    .x_base_addr_o    (x_base_addr_o),
    .w_base_addr_o    (w_base_addr_o),
    .w_stride_o       (w_stride_o),
    .wq_d2_stride_o   (wq_d2_stride_o),
    .x_tot_len_o      (x_tot_len_o),
    .x_req_start_o    (x_req_start_o),
    .w_req_start_o    (w_req_start_o),
    .wq_req_start_o   (wq_req_start_o),
    .ignore_bias_o    (ignore_bias_o)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== testbench/tb_mem_scheduler.sv ====
`include "mem_sched_params.svh"

module tb_mem_scheduler;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LenW          = $clog2(`MS_ARRAY_W) + 1;
  localparam int unsigned XJump         = 12;
  localparam int unsigned TestCycles    = 400;
  localparam int unsigned TimeoutCycles = 5 * TestCycles;

  logic clk_i;
  logic rst_ni;
  logic clear_i;
  logic x_done_i;
  mem_sched_pkg::iter_t cols_iters_i, rows_iters_i, w_iters_i, tot_x_read_i;
  mem_sched_pkg::addr_t rows_offs_i;
  logic [LenW-1:0] leftover_rows_i;
  mem_sched_pkg::addr_t x_addr_i, w_addr_i, scales_addr_i, w_d0_stride_i;
  logic dequant_en_i, first_load_i;
  logic x_ready_start_i, w_ready_start_i, wq_ready_start_i;
  mem_sched_pkg::qmode_e qmode_i;
  logic gidx_valid_i, offs_ready_i, row_valid_i, wq_ready_i;
  mem_sched_pkg::gidx_word_t gidx_i;
  mem_sched_pkg::iter_t row_idx_i;
  logic gidx_ready_o, offs_valid_o, group_skip_o, row_ready_o, wq_valid_o;
  mem_sched_pkg::addr_t scales_offs_o, zeros_offs_o, wq_offs_o;
  mem_sched_pkg::addr_t x_base_addr_o, w_base_addr_o, w_stride_o, wq_d2_stride_o;
  logic [LenW-1:0] x_tot_len_o;
  logic x_req_start_o, w_req_start_o, wq_req_start_o, ignore_bias_o;

  int unsigned value_errs = 0;
  int unsigned other_errs = 0;
  int unsigned cycle_cnt  = 0;
  logic [31:0] rng_state  = 32'h7df4;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  mem_scheduler_top mem_scheduler_top_i (.*);

  // Reference loop position kept as plain tile indices
  mem_sched_pkg::iter_t m_col, m_wpass, m_row, m_reads;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {m_col, m_wpass, m_row, m_reads} <= '0;
    end else if (clear_i) begin
      {m_col, m_wpass, m_row, m_reads} <= '0;
    end else if (x_done_i) begin
      m_reads <= m_reads + 16'd1;
      if (m_col + 16'd1 < cols_iters_i) begin
        m_col <= m_col + 16'd1;
      end else begin
        m_col <= '0;
        if (m_wpass + 16'd1 < w_iters_i) begin
          m_wpass <= m_wpass + 16'd1;
        end else begin
          m_wpass <= '0;
          m_row   <= (m_row + 16'd1 < rows_iters_i) ? m_row + 16'd1 : '0;
        end
      end
    end
  end

  mem_sched_pkg::addr_t exp_x_base, exp_w_base, exp_w_stride, exp_wq_d2;
  mem_sched_pkg::addr_t exp_scales, exp_zeros, exp_wq_offs;
  logic [LenW-1:0] exp_len;
  logic exp_reload, exp_x_req, exp_w_req, exp_wq_req;
  logic [15:0] stride_lo, stride_div;
  int unsigned mode_div;

  always_comb begin
    case (qmode_i)
      mem_sched_pkg::QINT_2: mode_div = 8;
      mem_sched_pkg::QINT_4: mode_div = 4;
      default:               mode_div = 2;
    endcase
    exp_x_base = x_addr_i + mem_sched_pkg::addr_t'(m_col) * XJump
               + mem_sched_pkg::addr_t'(m_row) * rows_offs_i;
    exp_len = (m_row == rows_iters_i - 16'd1 && leftover_rows_i != '0) ? leftover_rows_i
                                                                       : LenW'(4);
    exp_reload   = (m_reads != '0) && (m_reads != tot_x_read_i);
    exp_x_req    = (first_load_i || exp_reload) && x_ready_start_i;
    exp_w_req    = first_load_i && w_ready_start_i;
    exp_wq_req   = dequant_en_i && first_load_i && wq_ready_start_i;
    exp_w_base   = dequant_en_i ? scales_addr_i : w_addr_i;
    exp_w_stride = dequant_en_i ? '0 : w_d0_stride_i;
    exp_wq_d2    = mem_sched_pkg::addr_t'(XJump / mode_div);
    stride_lo    = w_d0_stride_i[15:0];
    stride_div   = 16'(stride_lo / mode_div);
    exp_scales   = mem_sched_pkg::addr_t'(gidx_i.idx) * mem_sched_pkg::addr_t'(stride_lo);
    exp_zeros    = mem_sched_pkg::addr_t'(gidx_i.idx) * mem_sched_pkg::addr_t'(stride_div);
    exp_wq_offs  = mem_sched_pkg::addr_t'(row_idx_i) * mem_sched_pkg::addr_t'(stride_div);
  end

  task automatic value_error(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    value_errs++;
    $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
  endtask

  task automatic print_summary();
    $display("Run ended after %0d cycles with %0d value errors and %0d other errors",
             cycle_cnt, value_errs, other_errs);
  endtask

  a_x_base : assert property (@(posedge clk_i) disable iff (!rst_ni) x_base_addr_o == exp_x_base)
    else value_error("x_base_addr_o", $sampled(x_base_addr_o), $sampled(exp_x_base));
  a_x_len : assert property (@(posedge clk_i) disable iff (!rst_ni) x_tot_len_o == exp_len)
    else value_error("x_tot_len_o", 32'($sampled(x_tot_len_o)), 32'($sampled(exp_len)));
  a_x_req : assert property (@(posedge clk_i) disable iff (!rst_ni) x_req_start_o == exp_x_req)
    else value_error("x_req_start_o", 32'($sampled(x_req_start_o)), 32'($sampled(exp_x_req)));
  a_w_req : assert property (@(posedge clk_i) disable iff (!rst_ni) w_req_start_o == exp_w_req)
    else value_error("w_req_start_o", 32'($sampled(w_req_start_o)), 32'($sampled(exp_w_req)));
  a_wq_req : assert property (@(posedge clk_i) disable iff (!rst_ni) wq_req_start_o == exp_wq_req)
    else value_error("wq_req_start_o", 32'($sampled(wq_req_start_o)), 32'($sampled(exp_wq_req)));
  a_w_base : assert property (@(posedge clk_i) disable iff (!rst_ni) w_base_addr_o == exp_w_base)
    else value_error("w_base_addr_o", $sampled(w_base_addr_o), $sampled(exp_w_base));
  a_w_stride : assert property (@(posedge clk_i) disable iff (!rst_ni) w_stride_o == exp_w_stride)
    else value_error("w_stride_o", $sampled(w_stride_o), $sampled(exp_w_stride));
  a_ignore : assert property (@(posedge clk_i) disable iff (!rst_ni) ignore_bias_o == !dequant_en_i)
    else value_error("ignore_bias_o", 32'($sampled(ignore_bias_o)), 32'(!$sampled(dequant_en_i)));
  a_wq_d2 : assert property (@(posedge clk_i) disable iff (!rst_ni) wq_d2_stride_o == exp_wq_d2)
    else value_error("wq_d2_stride_o", $sampled(wq_d2_stride_o), $sampled(exp_wq_d2));
  a_scales : assert property (@(posedge clk_i) disable iff (!rst_ni) scales_offs_o == exp_scales)
    else value_error("scales_offs_o", $sampled(scales_offs_o), $sampled(exp_scales));
  a_zeros : assert property (@(posedge clk_i) disable iff (!rst_ni) zeros_offs_o == exp_zeros)
    else value_error("zeros_offs_o", $sampled(zeros_offs_o), $sampled(exp_zeros));
  a_wq_offs : assert property (@(posedge clk_i) disable iff (!rst_ni) wq_offs_o == exp_wq_offs)
    else value_error("wq_offs_o", $sampled(wq_offs_o), $sampled(exp_wq_offs));
  a_skip : assert property (@(posedge clk_i) disable iff (!rst_ni) group_skip_o == gidx_i.skip)
    else value_error("group_skip_o", 32'($sampled(group_skip_o)), 32'($sampled(gidx_i.skip)));
  a_offs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    offs_valid_o == (gidx_valid_i && offs_ready_i))
    else value_error("offs_valid_o", 32'($sampled(offs_valid_o)),
                     32'($sampled(gidx_valid_i) && $sampled(offs_ready_i)));
  a_gidx_ready : assert property (@(posedge clk_i) disable iff (!rst_ni) gidx_ready_o == offs_ready_i)
    else value_error("gidx_ready_o", 32'($sampled(gidx_ready_o)), 32'($sampled(offs_ready_i)));
  a_wq_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wq_valid_o == (row_valid_i && wq_ready_i))
    else value_error("wq_valid_o", 32'($sampled(wq_valid_o)),
                     32'($sampled(row_valid_i) && $sampled(wq_ready_i)));
  a_row_ready : assert property (@(posedge clk_i) disable iff (!rst_ni) row_ready_o == wq_ready_i)
    else value_error("row_ready_o", 32'($sampled(row_ready_o)), 32'($sampled(wq_ready_i)));

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng_state = lcg_step(rng_state);
    v = rng_state;
  endtask

  task automatic pulse_done();
    logic [31:0] r;
    next_rand(r);
    @(posedge clk_i);
    x_done_i        <= 1'b1;
    x_ready_start_i <= r[20] | r[22];
    @(posedge clk_i);
    x_done_i <= 1'b0;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      other_errs++;
      $display("Timeout, the test sequence was still running after %0d cycles", cycle_cnt);
      print_summary();
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] u;
    clear_i          = 1'b0;
    x_done_i         = 1'b0;
    cols_iters_i     = 16'd1;
    rows_iters_i     = 16'd1;
    w_iters_i        = 16'd1;
    rows_offs_i      = '0;
    tot_x_read_i     = '0;
    leftover_rows_i  = '0;
    x_addr_i         = 32'h1000_0000;
    w_addr_i         = 32'h3000_0000;
    scales_addr_i    = 32'h4000_0000;
    w_d0_stride_i    = 32'h0000_0040;
    dequant_en_i     = 1'b0;
    first_load_i     = 1'b0;
    x_ready_start_i  = 1'b0;
    w_ready_start_i  = 1'b0;
    wq_ready_start_i = 1'b0;
    qmode_i          = mem_sched_pkg::QINT_8;
    gidx_valid_i     = 1'b0;
    gidx_i           = '0;
    offs_ready_i     = 1'b0;
    row_valid_i      = 1'b0;
    row_idx_i        = '0;
    wq_ready_i       = 1'b0;

    @(posedge rst_ni);
    // Idle with all enables low
    repeat (4) @(posedge clk_i);

    // Walk 3 columns, 2 W passes and 3 rows with leftovers on the last row
    @(posedge clk_i);
    cols_iters_i    <= 16'd3;
    w_iters_i       <= 16'd2;
    rows_iters_i    <= 16'd3;
    rows_offs_i     <= 32'h0000_0100;
    tot_x_read_i    <= 16'd18;
    leftover_rows_i <= LenW'(2);
    x_addr_i        <= 32'h2000_0000;
    clear_i         <= 1'b1;
    first_load_i    <= 1'b1;
    x_ready_start_i <= 1'b1;
    w_ready_start_i <= 1'b1;
    @(posedge clk_i);
    clear_i      <= 1'b0;
    first_load_i <= 1'b0;
    repeat (40) pulse_done();

    // Clear in the middle of a walk
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;

    // Dequant mode in each quantisation mode, then back to plain W
    for (int i = 0; i < 30; i++) begin
      next_rand(r);
      next_rand(s);
      @(posedge clk_i);
      dequant_en_i     <= (i < 24);
      qmode_i          <= mem_sched_pkg::qmode_e'(2'((i / 8) % 3));
      first_load_i     <= r[16] | r[17];
      x_ready_start_i  <= r[18];
      w_ready_start_i  <= r[19];
      wq_ready_start_i <= r[20] | r[21];
      scales_addr_i    <= {s[31:16], 16'h0};
      w_d0_stride_i    <= {16'h0, s[31:16]};
    end

    // Random group and row indices with back-pressure
    for (int i = 0; i < 200; i++) begin
      next_rand(r);
      next_rand(s);
      next_rand(t);
      next_rand(u);
      @(posedge clk_i);
      first_load_i  <= 1'b0;
      gidx_valid_i  <= r[16];
      offs_ready_i  <= r[17] | r[18];
      row_valid_i   <= r[19];
      wq_ready_i    <= r[20] | r[21];
      qmode_i       <= mem_sched_pkg::qmode_e'(2'(r[27:24] % 4'd3));
      gidx_i        <= mem_sched_pkg::gidx_word_t'(s[31:23]);
      row_idx_i     <= t[31:16];
      w_d0_stride_i <= {s[15:0], u[31:16]};
    end

    repeat (3) @(posedge clk_i);
    print_summary();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== mem_scheduler.f ====
+incdir+rtl
rtl/mem_sched_pkg.sv
rtl/loop_cfg_if.sv
rtl/x_tile_walker.sv
rtl/dequant_offset_gen.sv
rtl/stream_ctrl_builder.sv
rtl/mem_scheduler_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_scheduler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --top-module tb_mem_scheduler \
  -f mem_scheduler.f -o tb_mem_scheduler \
  && ./obj_dir/tb_mem_scheduler > "$log" 2>&1 \
  || { cat "$log" 2>/dev/null; echo "Build or run error"; exit 1; }

cat "$log"
grep -q "Simulation FAILED" "$log" && exit 1 || exit 0
